// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dma -f list.f -o sim
	./obj_dir/sim 2>&1 | tee sim.log
	@if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== dma_beat_timer.sv ====
// ----------------------------------------
// burst beat counter and job cycle timer
// ----------------------------------------
`timescale 1ns/10ps

module dma_beat_timer #(
   parameter int TIMER_W = 32
) (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  logic               beat_clr_i,
   input  logic               ack_i,
   input  logic               we_i,
   input  logic               timer_clr_i,
   input  logic               run_i,
   output logic [1:0]         beat_idx_o,
   output logic               last_beat_o,
   output logic [TIMER_W-1:0] job_cycles_o
);

   logic [1:0]         beat_q;
   logic [TIMER_W-1:0] cyc_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         beat_q <= 2'd0;
      else if (beat_clr_i)
         beat_q <= 2'd0;
      else if (ack_i)
         beat_q <= beat_q + 2'd1;   // stalled ack holds the count
   end

   assign beat_idx_o  = beat_q;
   // write-back is a single beat, fetch is the full descriptor
   assign last_beat_o = ack_i && (we_i ? (beat_q == 2'd0)
                                       : (beat_q == 2'(dma_pkg::DESC_BEATS - 1)));

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         cyc_q <= '0;
      else if (timer_clr_i)
         cyc_q <= TIMER_W'(1);      // handshake edge is the first
      else if (run_i)
         cyc_q <= cyc_q + TIMER_W'(1);
   end

   assign job_cycles_o = cyc_q + TIMER_W'(1);   // includes the edge in progress

endmodule

// ==== dma_bus_master.sv ====
// ----------------------------------------
// Wishbone master for descriptor bursts
// fetch reads and the status write-back
// ----------------------------------------
`timescale 1ns/10ps

module dma_bus_master #(
   parameter int TIMER_W = 32
) (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  logic               burst_start_i,
   input  logic               burst_we_i,
   input  logic [31:3]        burst_adr_i,
   input  logic               last_beat_i,
   input  logic               wbm_ack_i,
   input  logic [31:0]        chan_result_i,
   input  logic [TIMER_W-1:0] job_cycles_i,
   output logic               wbm_cyc_o,
   output logic               wbm_stb_o,
   output logic               wbm_we_o,
   output logic [7:0]         wbm_sel_o,
   output logic [31:0]        wbm_adr_o,
   output logic [63:0]        wbm_dat_o
);

   logic [31:3] adr_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbm_cyc_o <= 1'b0;
         wbm_stb_o <= 1'b0;
         wbm_we_o  <= 1'b0;
         wbm_sel_o <= 8'h00;
      end else if (burst_start_i) begin
         wbm_cyc_o <= 1'b1;          // cyc and stb rise together
         wbm_stb_o <= 1'b1;
         wbm_we_o  <= burst_we_i;
         wbm_sel_o <= 8'hff;         // full 64-bit beats only
      end else if (last_beat_i) begin
         wbm_cyc_o <= 1'b0;
         wbm_stb_o <= 1'b0;
         wbm_we_o  <= 1'b0;
         wbm_sel_o <= 8'h00;
      end
   end

   // burst address, one 8-byte step per ack
   always_ff @(posedge wb_clk_i) begin
      if (burst_start_i)
         adr_q <= burst_adr_i;
      else if (wbm_ack_i)
         adr_q <= adr_q + 29'd1;
   end

   assign wbm_adr_o = {adr_q, 3'b000};

   // status beat, sampled on the done edge where the result is valid
   always_ff @(posedge wb_clk_i) begin
      if (burst_start_i && burst_we_i)
         wbm_dat_o <= {32'(job_cycles_i), chan_result_i};
   end

endmodule

// ==== dma_ctrl_checker.sv ====
// ----------------------------------------
// protocol assertions on the DMA top level
// ----------------------------------------
`timescale 1ns/10ps

module dma_ctrl_checker (
   input logic        wb_clk_i,
   input logic        wb_rst_i,
   input logic        wbm_cyc_o,
   input logic        wbm_stb_o,
   input logic        wbm_ack_i,
   input logic        job_valid_o,
   input logic        job_ready_i,
   input logic [31:0] job_src_o,
   input logic [31:0] job_dst_o,
   input logic [23:0] job_ctl_o,
   input logic        busy_o
);

   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbm_stb_o |-> wbm_cyc_o)
      else $error("stb high without cyc");

   a_job_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (job_valid_o && !job_ready_i) |=>
         ($stable(job_src_o) && $stable(job_dst_o) && $stable(job_ctl_o)))
      else $error("job fields changed while waiting for ready");

   a_ack_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbm_ack_i |-> wbm_cyc_o)
      else $error("ack outside a bus cycle");

   a_idle_after_rst: assert property (@(posedge wb_clk_i)
      $fell(wb_rst_i) |-> !busy_o)
      else $error("busy right after reset");

endmodule

// ==== dma_ctrl_top.sv ====
// ----------------------------------------
// DMA descriptor control engine top level
// 64-bit Wishbone master, one channel
// ----------------------------------------
`timescale 1ns/10ps

module dma_ctrl_top #(
   parameter int TIMER_W = 32
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        enable_i,
   input  logic        ndar_valid_i,
   input  logic [31:3] ndar_i,
   output logic        ndar_ready_o,
   output logic        job_valid_o,
   input  logic        job_ready_i,
   output logic [31:0] job_src_o,
   output logic [31:0] job_dst_o,
   output logic [23:0] job_ctl_o,
   input  logic        chan_done_i,
   input  logic [31:0] chan_result_i,
   output logic        wbm_cyc_o,
   output logic        wbm_stb_o,
   output logic        wbm_we_o,
   output logic [7:0]  wbm_sel_o,
   output logic [31:0] wbm_adr_o,
   output logic [63:0] wbm_dat_o,
   input  logic [63:0] wbm_dat_i,
   input  logic        wbm_ack_i,
   input  logic        int_clear_i,
   output logic        wb_int_o,
   output logic        busy_o,
   output logic [31:0] dar_o
);

   logic               burst_start, burst_we, beat_clr, last_beat, fetch_ack;
   logic               job_issue, timer_clr, job_finish, irq_set;
   logic [31:3]        burst_adr, next_adr, stat_adr;
   logic [1:0]         beat_idx;
   logic [23:0]        ctl;
   logic [TIMER_W-1:0] job_cycles;

   assign fetch_ack = wbm_ack_i && !wbm_we_o;   // read data only

   dma_desc_fsm u_fsm (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .enable_i(enable_i),
      .ndar_valid_i(ndar_valid_i), .ndar_i(ndar_i), .job_ready_i(job_ready_i),
      .chan_done_i(chan_done_i), .last_beat_i(last_beat), .ctl_i(ctl),
      .next_adr_i(next_adr), .stat_adr_i(stat_adr), .ndar_ready_o(ndar_ready_o),
      .busy_o(busy_o), .burst_start_o(burst_start), .burst_we_o(burst_we),
      .burst_adr_o(burst_adr), .beat_clr_o(beat_clr), .job_issue_o(job_issue),
      .timer_clr_o(timer_clr), .job_finish_o(job_finish), .irq_set_o(irq_set));

   // job timer restarts at each issue handshake
   dma_beat_timer #(.TIMER_W(TIMER_W)) u_timer (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .beat_clr_i(beat_clr),
      .ack_i(wbm_ack_i), .we_i(wbm_we_o), .timer_clr_i(timer_clr), .run_i(busy_o),
      .beat_idx_o(beat_idx), .last_beat_o(last_beat), .job_cycles_o(job_cycles));

   dma_bus_master #(.TIMER_W(TIMER_W)) u_bus (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .burst_start_i(burst_start),
      .burst_we_i(burst_we), .burst_adr_i(burst_adr), .last_beat_i(last_beat),
      .wbm_ack_i(wbm_ack_i), .chan_result_i(chan_result_i), .job_cycles_i(job_cycles),
      .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o), .wbm_we_o(wbm_we_o),
      .wbm_sel_o(wbm_sel_o), .wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o));

   dma_desc_regs u_regs (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .fetch_ack_i(fetch_ack),
      .beat_idx_i(beat_idx), .wbm_dat_i(wbm_dat_i), .job_issue_i(job_issue),
      .job_ready_i(job_ready_i), .job_finish_i(job_finish),
      .desc_adr_i(wbm_adr_o[31:3]), .irq_set_i(irq_set), .int_clear_i(int_clear_i),
      .next_adr_o(next_adr), .stat_adr_o(stat_adr), .ctl_o(ctl),
      .job_valid_o(job_valid_o), .job_src_o(job_src_o), .job_dst_o(job_dst_o),
      .job_ctl_o(job_ctl_o), .dar_o(dar_o), .wb_int_o(wb_int_o));

endmodule

// ==== dma_desc_fsm.sv ====
// ----------------------------------------
// DMA descriptor sequencer
// fetch, issue, run, write-back, done
// follows the chain until CTL_CHAIN clear
// ----------------------------------------
`timescale 1ns/10ps

module dma_desc_fsm (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        enable_i,
   input  logic        ndar_valid_i,
   input  logic [31:3] ndar_i,
   input  logic        job_ready_i,
   input  logic        chan_done_i,
   input  logic        last_beat_i,
   input  logic [23:0] ctl_i,
   input  logic [31:3] next_adr_i,
   input  logic [31:3] stat_adr_i,
   output logic        ndar_ready_o,
   output logic        busy_o,
   output logic        burst_start_o,
   output logic        burst_we_o,
   output logic [31:3] burst_adr_o,
   output logic        beat_clr_o,
   output logic        job_issue_o,
   output logic        timer_clr_o,
   output logic        job_finish_o,
   output logic        irq_set_o
);

   dma_pkg::dma_state_e state_q;
   dma_pkg::dma_state_e state_d;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         state_q <= dma_pkg::S_IDLE;
      else
         state_q <= state_d;
   end

   assign ndar_ready_o = (state_q == dma_pkg::S_IDLE) && enable_i;
   assign busy_o       = (state_q != dma_pkg::S_IDLE);
   assign beat_clr_o   = burst_start_o;   // every burst counts from beat 0

   always_comb begin
      state_d       = state_q;
      burst_start_o = 1'b0;
      burst_we_o    = 1'b0;
      burst_adr_o   = ndar_i;
      job_issue_o   = 1'b0;
      timer_clr_o   = 1'b0;
      job_finish_o  = 1'b0;
      irq_set_o     = 1'b0;
      case (state_q)
         dma_pkg::S_IDLE: begin
            if (ndar_valid_i && ndar_ready_o) begin
               burst_start_o = 1'b1;              // fetch from software address
               state_d       = dma_pkg::S_FETCH;
            end
         end
         dma_pkg::S_FETCH: begin
            if (last_beat_i) begin
               job_issue_o = 1'b1;                // dst lands on this same edge
               state_d     = dma_pkg::S_ISSUE;
            end
         end
         dma_pkg::S_ISSUE: begin
            if (job_ready_i) begin
               timer_clr_o = 1'b1;
               state_d     = dma_pkg::S_RUN;
            end
         end
         dma_pkg::S_RUN: begin
            if (chan_done_i) begin
               if (ctl_i[dma_pkg::CTL_WBACK]) begin
                  burst_start_o = 1'b1;
                  burst_we_o    = 1'b1;
                  burst_adr_o   = stat_adr_i;
                  state_d       = dma_pkg::S_WBACK;
               end else begin
                  state_d = dma_pkg::S_DONE;
               end
            end
         end
         dma_pkg::S_WBACK: begin
            if (last_beat_i)
               state_d = dma_pkg::S_DONE;
         end
         dma_pkg::S_DONE: begin
            job_finish_o = 1'b1;
            irq_set_o    = ctl_i[dma_pkg::CTL_IRQ];
            if (ctl_i[dma_pkg::CTL_CHAIN]) begin
               burst_start_o = 1'b1;
               burst_adr_o   = next_adr_i;        // straight into the next fetch
               state_d       = dma_pkg::S_FETCH;
            end else begin
               state_d = dma_pkg::S_IDLE;
            end
         end
         default: state_d = dma_pkg::S_IDLE;
      endcase
   end

endmodule

// ==== dma_desc_regs.sv ====
// ----------------------------------------
// descriptor field capture and job hold
// last finished address, sticky interrupt
// ----------------------------------------
`timescale 1ns/10ps

module dma_desc_regs (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        fetch_ack_i,
   input  logic [1:0]  beat_idx_i,
   input  logic [63:0] wbm_dat_i,
   input  logic        job_issue_i,
   input  logic        job_ready_i,
   input  logic        job_finish_i,
   input  logic [31:3] desc_adr_i,
   input  logic        irq_set_i,
   input  logic        int_clear_i,
   output logic [31:3] next_adr_o,
   output logic [31:3] stat_adr_o,
   output logic [23:0] ctl_o,
   output logic        job_valid_o,
   output logic [31:0] job_src_o,
   output logic [31:0] job_dst_o,
   output logic [23:0] job_ctl_o,
   output logic [31:0] dar_o,
   output logic        wb_int_o
);

   dma_pkg::desc_beat_u beat;
   logic [31:3]         cur_adr_q;

   assign beat = wbm_dat_i;

   always_ff @(posedge wb_clk_i) begin
      if (fetch_ack_i) begin
         case (beat_idx_i)
            2'd0: begin
               next_adr_o <= beat.link.next_adr[31:3];
               stat_adr_o <= beat.link.stat_adr[31:3];
               cur_adr_q  <= desc_adr_i;              // bus address of beat 0
            end
            2'd1: ctl_o     <= beat.ctrl.ctl;
            2'd2: job_src_o <= beat.link.next_adr;
            2'd3: job_dst_o <= beat.link.next_adr;
            default: ;
         endcase
      end
   end

   assign job_ctl_o = ctl_o;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         job_valid_o <= 1'b0;
      else if (job_issue_i)
         job_valid_o <= 1'b1;
      else if (job_ready_i)
         job_valid_o <= 1'b0;   // held until the channel takes it
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         dar_o <= 32'h0;
      else if (job_finish_i)
         dar_o <= {cur_adr_q, 3'b000};
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         wb_int_o <= 1'b0;
      else if (irq_set_i)
         wb_int_o <= 1'b1;      // set wins over clear
      else if (int_clear_i)
         wb_int_o <= 1'b0;
   end

endmodule

// ==== dma_pkg.sv ====
// ----------------------------------------
// DMA descriptor engine shared definitions
// FSM states, control bits, beat decoding
// ----------------------------------------
package dma_pkg;

   typedef enum logic [2:0] {
      S_IDLE  = 3'd0,
      S_FETCH = 3'd1,
      S_ISSUE = 3'd2,
      S_RUN   = 3'd3,
      S_WBACK = 3'd4,
      S_DONE  = 3'd5
   } dma_state_e;

   localparam int CTL_WBACK  = 7;    // write status beat
   localparam int CTL_CHAIN  = 14;   // follow next_adr
   localparam int CTL_IRQ    = 15;   // interrupt when done
   localparam int DESC_BEATS = 4;    // 64-bit beats per descriptor

   // one fetched bus word, read as link or as control
   typedef union packed {
      struct packed {
         logic [31:0] stat_adr;      // status write-back address
         logic [31:0] next_adr;      // chain pointer, also src/dst
      } link;
      struct packed {
         logic [31:0] unused;
         logic [7:0]  rsvd;
         logic [23:0] ctl;
      } ctrl;
   } desc_beat_u;

endpackage

// ==== list.f ====
dma_pkg.sv
dma_desc_fsm.sv
dma_beat_timer.sv
dma_bus_master.sv
dma_desc_regs.sv
dma_ctrl_top.sv
dma_ctrl_checker.sv
tb_clkgen.sv
tb_dma_monitor.sv
tb_dma.sv

// ==== tb_clkgen.sv ====
// ----------------------------------------
// testbench clock and reset source
// 8 ns period, reset held for 5 cycles
// ----------------------------------------
`timescale 1ns/10ps

module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (5) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;   // release away from the sampling edge
   end

endmodule

// ==== tb_dma.sv ====
// ----------------------------------------
// DMA control engine testbench
// memory slave, channel model, random chains
// ----------------------------------------
`timescale 1ns/10ps

module tb_dma;

   localparam int NCHAINS = 6;

   logic        clk, rst;
   logic        enable_i, ndar_valid_i, ndar_ready_o;
   logic [31:3] ndar_i;
   logic        job_valid_o, job_ready_i, chan_done_i;
   logic [31:0] job_src_o, job_dst_o, chan_result_i;
   logic [23:0] job_ctl_o;
   logic        wbm_cyc_o, wbm_stb_o, wbm_we_o, wbm_ack_i;
   logic [7:0]  wbm_sel_o;
   logic [31:0] wbm_adr_o, dar_o;
   logic [63:0] wbm_dat_o, wbm_dat_i;
   logic        int_clear_i, wb_int_o, busy_o;
   logic [63:0] mem [0:511];
   integer      seed, seed_bus, seed_chan;
   int          dly, n, len, errs;
   logic [31:0] adr, stat, src, dst;
   logic [23:0] ctl;

   tb_clkgen u_clk (.clk_o(clk), .rst_o(rst));

   dma_ctrl_top #(.TIMER_W(32)) uut (
      .wb_clk_i(clk), .wb_rst_i(rst), .enable_i(enable_i), .ndar_valid_i(ndar_valid_i),
      .ndar_i(ndar_i), .ndar_ready_o(ndar_ready_o), .job_valid_o(job_valid_o),
      .job_ready_i(job_ready_i), .job_src_o(job_src_o), .job_dst_o(job_dst_o),
      .job_ctl_o(job_ctl_o), .chan_done_i(chan_done_i), .chan_result_i(chan_result_i),
      .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o), .wbm_we_o(wbm_we_o),
      .wbm_sel_o(wbm_sel_o), .wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o),
      .wbm_dat_i(wbm_dat_i), .wbm_ack_i(wbm_ack_i), .int_clear_i(int_clear_i),
      .wb_int_o(wb_int_o), .busy_o(busy_o), .dar_o(dar_o));

   bind dma_ctrl_top dma_ctrl_checker u_chk (.*);

   tb_dma_monitor u_mon (
      .clk_i(clk), .rst_i(rst), .enable_i(enable_i), .ndar_valid_i(ndar_valid_i),
      .ndar_ready_i(ndar_ready_o), .job_valid_i(job_valid_o), .job_ready_i(job_ready_i),
      .job_src_i(job_src_o), .job_dst_i(job_dst_o), .job_ctl_i(job_ctl_o),
      .chan_done_i(chan_done_i), .chan_result_i(chan_result_i), .wbm_cyc_i(wbm_cyc_o),
      .wbm_we_i(wbm_we_o), .wbm_ack_i(wbm_ack_i), .wbm_sel_i(wbm_sel_o),
      .wbm_adr_i(wbm_adr_o), .wr_dat_i(wbm_dat_o), .int_clear_i(int_clear_i),
      .wb_int_i(wb_int_o), .busy_i(busy_o), .dar_i(dar_o));

   // memory slave, 0 to 3 wait cycles per beat
   initial begin
      wbm_ack_i = 1'b0;
      wbm_dat_i = '0;
      dly       = 0;
      for (int i = 0; i < 512; i++)
         mem[i] = {~32'(i * 8), 32'(i * 8) ^ 32'h5a5a0000};
      forever begin
         @(negedge clk);
         if (!wbm_cyc_o || wbm_ack_i) begin
            wbm_ack_i = 1'b0;
            dly       = {$random(seed_bus)} % 4;
         end else if (wbm_stb_o && dly == 0) begin
            wbm_ack_i = 1'b1;
            wbm_dat_i = mem[wbm_adr_o[11:3]];
            if (wbm_we_o)
               mem[wbm_adr_o[11:3]] = wbm_dat_o;
         end else if (dly > 0) begin
            dly--;
         end
      end
   end

   // channel: stalls ready, then runs and reports
   initial begin
      job_ready_i   = 1'b0;
      chan_done_i   = 1'b0;
      chan_result_i = '0;
      forever begin
         @(negedge clk);
         if (job_valid_o) begin
            repeat ({$random(seed_chan)} % 4) @(negedge clk);
            job_ready_i = 1'b1;
            @(negedge clk);
            job_ready_i = 1'b0;
            repeat ({$random(seed_chan)} % 8) @(negedge clk);
            chan_result_i = $random(seed_chan);
            chan_done_i   = 1'b1;
            @(negedge clk);
            chan_done_i = 1'b0;
         end
      end
   end

   initial begin
      repeat (NCHAINS * 400) @(posedge clk);
      $display("timeout: engine still busy after %0d cycles", NCHAINS * 400);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      seed         = 32'h79c62f2e;
      seed_bus     = seed + 1;
      seed_chan    = seed + 2;
      enable_i     = 1'b0;
      ndar_valid_i = 1'b0;
      ndar_i       = '0;
      int_clear_i  = 1'b0;
      n            = 0;
      wait (!rst);
      @(negedge clk);
      for (int c = 0; c < NCHAINS; c++) begin
         len = 1 + {$random(seed)} % 5;
         for (int i = 0; i < len; i++) begin
            adr  = 32'h100 + 32'(n + i) * 32;
            stat = 32'hc00 + 32'(n + i) * 8;
            src  = $random(seed);
            dst  = $random(seed);
            ctl  = 24'($random(seed));
            ctl[dma_pkg::CTL_CHAIN] = (i < len - 1);
            mem[adr[11:3]]     = {stat, (i < len - 1) ? adr + 32 : 32'($random(seed)) & ~32'h7};
            mem[adr[11:3] + 1] = {32'($random(seed)), 8'h00, ctl};
            mem[adr[11:3] + 2] = {32'($random(seed)), src};
            mem[adr[11:3] + 3] = {32'($random(seed)), dst};
            u_mon.push_desc(adr, stat, src, dst, ctl);
         end
         ndar_i       = 29'((32'h100 + 32'(n) * 32) >> 3);
         ndar_valid_i = 1'b1;        // no transfer while disabled
         repeat (2) @(negedge clk);
         enable_i = 1'b1;
         @(negedge clk);
         while (!busy_o) @(negedge clk);   // handshake taken
         ndar_valid_i = 1'b0;
         while (busy_o) @(negedge clk);
         n += len;
         int_clear_i = 1'b1;
         @(negedge clk);
         int_clear_i = 1'b0;
         enable_i    = 1'b0;
         @(negedge clk);
      end
      repeat (10) @(negedge clk);
      u_mon.summarize(errs);
      if (errs == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== tb_dma_monitor.sv ====
// ----------------------------------------
// DMA port monitor with descriptor model
// checks jobs, write-back, dar and irq
// ----------------------------------------
`timescale 1ns/10ps

module tb_dma_monitor (
   input logic        clk_i,
   input logic        rst_i,
   input logic        enable_i,
   input logic        ndar_valid_i,
   input logic        ndar_ready_i,
   input logic        job_valid_i,
   input logic        job_ready_i,
   input logic [31:0] job_src_i,
   input logic [31:0] job_dst_i,
   input logic [23:0] job_ctl_i,
   input logic        chan_done_i,
   input logic [31:0] chan_result_i,
   input logic        wbm_cyc_i,
   input logic        wbm_we_i,
   input logic        wbm_ack_i,
   input logic [7:0]  wbm_sel_i,
   input logic [31:0] wbm_adr_i,
   input logic [63:0] wr_dat_i,
   input logic        int_clear_i,
   input logic        wb_int_i,
   input logic        busy_i,
   input logic [31:0] dar_i
);

   logic [31:0] q_adr[$];
   logic [31:0] q_stat[$];
   logic [31:0] q_src[$];
   logic [31:0] q_dst[$];
   logic [23:0] q_ctl[$];
   logic [31:0] cur_adr = '0;
   logic [31:0] cur_stat = '0;
   logic [23:0] cur_ctl = '0;
   logic [31:0] result = '0;
   logic [31:0] last_dar = '0;
   logic        running = 1'b0;
   logic        exp_int = 1'b0;
   logic        exp_idle = 1'b1;
   int          cycles = 0;
   int          nwr = 0;
   int          jobs = 0;
   int          finished = 0;
   int          errors = 0;

   task push_desc(input logic [31:0] adr, input logic [31:0] stat, input logic [31:0] src,
                  input logic [31:0] dst, input logic [23:0] ctl);
      q_adr.push_back(adr);
      q_stat.push_back(stat);
      q_src.push_back(src);
      q_dst.push_back(dst);
      q_ctl.push_back(ctl);
   endtask

   task mismatch(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      errors++;
   endtask

   // pre-edge values, so the DUT's own updates never race the model
   always @(posedge clk_i) begin
      if (!rst_i) begin
         if (ndar_ready_i !== (exp_idle && enable_i))
            mismatch($sformatf("ndar_ready_o %b expected %b", ndar_ready_i,
                               exp_idle && enable_i));
         if (busy_i !== !exp_idle)
            mismatch($sformatf("busy_o %b expected %b", busy_i, !exp_idle));
         if (ndar_valid_i && ndar_ready_i)
            exp_idle = 1'b0;   // list accepted, fetch begins
         if (job_valid_i && job_ready_i) begin
            if (q_adr.size() == 0) begin
               $display("error at %0t: job issued with no descriptor pending", $time);
               errors++;
            end else begin
               cur_adr  = q_adr.pop_front();
               cur_stat = q_stat.pop_front();
               cur_ctl  = q_ctl.pop_front();
               if (job_src_i !== q_src[0])
                  mismatch($sformatf("src %h expected %h", job_src_i, q_src[0]));
               if (job_dst_i !== q_dst[0])
                  mismatch($sformatf("dst %h expected %h", job_dst_i, q_dst[0]));
               if (job_ctl_i !== cur_ctl)
                  mismatch($sformatf("ctl %h expected %h", job_ctl_i, cur_ctl));
               void'(q_src.pop_front());
               void'(q_dst.pop_front());
            end
            jobs++;
            running = 1'b1;
            cycles  = 1;       // handshake edge counts
            nwr     = 0;
         end else if (running) begin
            cycles++;
            if (chan_done_i) begin
               running = 1'b0;
               result  = chan_result_i;
            end
         end
         if (wbm_cyc_i && wbm_we_i && wbm_ack_i) begin
            nwr++;
            if (!cur_ctl[dma_pkg::CTL_WBACK])
               mismatch("status write without CTL_WBACK");
            if (wbm_adr_i !== cur_stat)
               mismatch($sformatf("write adr %h expected %h", wbm_adr_i, cur_stat));
            if (wbm_sel_i !== 8'hff)
               mismatch($sformatf("write sel %h", wbm_sel_i));
            if (wr_dat_i !== {32'(cycles), result})
               mismatch($sformatf("status %h expected %h", wr_dat_i,
                                  {32'(cycles), result}));
         end
         if (int_clear_i)
            exp_int = 1'b0;
      end
   end

   always @(negedge clk_i) begin
      if (!rst_i) begin
         if (dar_i !== last_dar) begin   // a descriptor just finished
            finished++;
            last_dar = dar_i;
            if (dar_i !== cur_adr)
               mismatch($sformatf("dar %h expected %h", dar_i, cur_adr));
            if (nwr != int'(cur_ctl[dma_pkg::CTL_WBACK]))
               mismatch($sformatf("%0d status writes for one job", nwr));
            exp_int  = exp_int | cur_ctl[dma_pkg::CTL_IRQ];
            exp_idle = !cur_ctl[dma_pkg::CTL_CHAIN];   // list ends without chain
         end
         if (wb_int_i !== exp_int)
            mismatch($sformatf("wb_int_o %b expected %b", wb_int_i, exp_int));
      end
   end

   task summarize(output int errs);
      if (q_adr.size() != 0) begin
         $display("error: %0d descriptors never issued", q_adr.size());
         errors++;
      end
      if (finished != jobs) begin
         $display("error: %0d jobs issued but %0d finished", jobs, finished);
         errors++;
      end
      $display("jobs %0d finished %0d errors %0d", jobs, finished, errors);
      errs = errors;
   endtask

endmodule
